/* verilog/cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

   localparam int xlen   = 32;
   localparam int reg_aw = 5;

   typedef enum logic [5:0] {
      op_alu  = 6'h01,
      op_addi = 6'h02,
      op_ori  = 6'h03
   } opcode_t;

   typedef enum logic [5:0] {
      f_add = 6'h00,
      f_sub = 6'h01,
      f_and = 6'h02,
      f_or  = 6'h03,
      f_xor = 6'h04
   } funct_t;

   // Register-register layout
   typedef struct packed {
      opcode_t           opcode;
      logic [reg_aw-1:0] rd;
      logic [reg_aw-1:0] rs1;
      logic [reg_aw-1:0] rs2;
      logic [4:0]        pad;
      funct_t            funct;
   } insn_r_t;

   // Immediate layout with a sign-extended imm
   typedef struct packed {
      opcode_t           opcode;
      logic [reg_aw-1:0] rd;
      logic [reg_aw-1:0] rs1;
      logic [15:0]       imm;
   } insn_i_t;

   typedef union packed {
      insn_r_t r;
      insn_i_t i;
   } insn_t;

   localparam logic [31:0] excp_vect_illegal = 32'h0000_0040;

endpackage

`default_nettype wire

/* verilog/pipe_if.sv */
`timescale 1ns/1ps
`default_nettype none

// Fetch to decode handoff
interface fetch_if;
   logic                     valid;
   logic                     ready;
   logic [cpu_pkg::xlen-1:0] pc;
   cpu_pkg::insn_t           insn;

   modport source (output valid, output pc, output insn, input ready);
   modport sink   (input valid, input pc, input insn, output ready);
endinterface

// Decode to execute without back-pressure
interface issue_if;
   logic                     valid;
   logic [cpu_pkg::xlen-1:0] pc;
   cpu_pkg::insn_t           insn;
   logic [cpu_pkg::xlen-1:0] op_a;
   logic [cpu_pkg::xlen-1:0] op_b;

   modport source (output valid, output pc, output insn, output op_a, output op_b);
   modport sink   (input valid, input pc, input insn, input op_a, input op_b);
endinterface

interface commit_if;
   logic                       valid;
   logic [cpu_pkg::xlen-1:0]   pc;
   cpu_pkg::insn_t             insn;
   logic                       we;
   logic [cpu_pkg::reg_aw-1:0] waddr;
   logic [cpu_pkg::xlen-1:0]   wdata;
   logic                       excp;

   modport source (output valid, output pc, output insn, output we, output waddr,
                   output wdata, output excp);
   modport sink   (input valid, input pc, input insn, input we, input waddr,
                   input wdata, input excp);
endinterface

`default_nettype wire

/* verilog/fetch_wb.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_wb
#(
   parameter logic [cpu_pkg::xlen-1:0] RESET_PC = '0
)
(
   input  logic                     clk,
   input  logic                     reset,
   output logic                     wb_cyc,
   output logic                     wb_stb,
   output logic [cpu_pkg::xlen-1:0] wb_adr,
   input  logic [cpu_pkg::xlen-1:0] wb_dat_i,
   input  logic                     wb_ack,
   fetch_if.source                  fetch
);
   logic [cpu_pkg::xlen-1:0] pc_q;

   assign wb_adr = pc_q;
   assign fetch.pc = pc_q;

   // One read in flight, or one word parked for decode
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         wb_cyc      <= 1'b0;
         wb_stb      <= 1'b0;
         fetch.valid <= 1'b0;
         pc_q        <= RESET_PC;
      end
      else if (wb_stb && wb_ack)
      begin
         wb_cyc      <= 1'b0;
         wb_stb      <= 1'b0;
         fetch.valid <= 1'b1;
      end
      else if (fetch.valid && fetch.ready)
      begin
         // Next request goes out as soon as decode takes the word
         wb_cyc      <= 1'b1;
         wb_stb      <= 1'b1;
         fetch.valid <= 1'b0;
         pc_q        <= pc_q + cpu_pkg::xlen'(4);
      end
      else if (!wb_cyc && !fetch.valid)
      begin
         wb_cyc <= 1'b1;
         wb_stb <= 1'b1;
      end
   end

   always_ff @(posedge clk)
   begin
      if (wb_stb && wb_ack)
         fetch.insn <= wb_dat_i;
   end

   a_stb_in_cyc: assert property (@(posedge clk) disable iff (reset) wb_stb |-> wb_cyc);

   a_adr_stable: assert property (@(posedge clk) disable iff (reset)
      wb_stb && !wb_ack |=> wb_stb && $stable(wb_adr));

endmodule

`default_nettype wire

/* verilog/decode_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module decode_stage
(
   input  logic     clk,
   input  logic     reset,
   fetch_if.sink    fetch,
   issue_if.source  issue,
   commit_if.sink   commit
);
   logic [cpu_pkg::xlen-1:0]   rf [0:(1 << cpu_pkg::reg_aw)-1];
   logic [cpu_pkg::reg_aw-1:0] src1;
   logic [cpu_pkg::reg_aw-1:0] src2;
   logic [cpu_pkg::reg_aw-1:0] iss_rd;
   logic                       src2_used;
   logic                       iss_wr;
   logic                       hazard;
   logic                       ready_en;

   // Register 0 reads zero and a same-cycle commit wins over the array
   function automatic logic [cpu_pkg::xlen-1:0] read_reg(input logic [cpu_pkg::reg_aw-1:0] a);
      logic [cpu_pkg::xlen-1:0] v;
      if (a == '0)
         v = '0;
      else if (commit.valid && commit.we && commit.waddr == a)
         v = commit.wdata;
      else
         v = rf[a];
      return v;
   endfunction

   assign src1      = fetch.insn.r.rs1;
   assign src2      = fetch.insn.r.rs2;
   assign src2_used = fetch.insn.r.opcode == cpu_pkg::op_alu;
   assign iss_rd    = issue.insn.r.rd;

   assign iss_wr = issue.valid && iss_rd != '0 &&
                   (issue.insn.r.opcode == cpu_pkg::op_alu ||
                    issue.insn.r.opcode == cpu_pkg::op_addi ||
                    issue.insn.r.opcode == cpu_pkg::op_ori);

   assign hazard = iss_wr && (src1 == iss_rd || (src2_used && src2 == iss_rd));

   // Execute never stalls, so the issue slot always frees
   assign fetch.ready = ready_en && !hazard;

   always_ff @(posedge clk)
   begin
      if (commit.valid && commit.we)
         rf[commit.waddr] <= commit.wdata;
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         ready_en    <= 1'b0;
         issue.valid <= 1'b0;
      end
      else
      begin
         ready_en    <= 1'b1;
         issue.valid <= fetch.valid && fetch.ready;
      end
   end

   always_ff @(posedge clk)
   begin
      if (fetch.valid && fetch.ready)
      begin
         issue.pc   <= fetch.pc;
         issue.insn <= fetch.insn;
         issue.op_a <= read_reg(src1);
         issue.op_b <= read_reg(src2);
      end
   end

   // Two back-to-back issues never carry a RAW dependency
   a_no_raw_issue: assert property (@(posedge clk) disable iff (reset)
      iss_wr |=> !(issue.valid && (issue.insn.r.rs1 == $past(iss_rd) ||
         (issue.insn.r.opcode == cpu_pkg::op_alu && issue.insn.r.rs2 == $past(iss_rd)))));

endmodule

`default_nettype wire

/* verilog/execute_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module execute_stage
(
   input  logic     clk,
   input  logic     reset,
   issue_if.sink    issue,
   commit_if.source commit
);
   logic [cpu_pkg::xlen-1:0] imm_sext;
   logic [cpu_pkg::xlen-1:0] result;
   logic                     illegal;

   assign imm_sext = {{(cpu_pkg::xlen-16){issue.insn.i.imm[15]}}, issue.insn.i.imm};

   always_comb
   begin
      result  = '0;
      illegal = 1'b0;
      case (issue.insn.r.opcode)
         cpu_pkg::op_alu:
            case (issue.insn.r.funct)
               cpu_pkg::f_add: result = issue.op_a + issue.op_b;
               cpu_pkg::f_sub: result = issue.op_a - issue.op_b;
               cpu_pkg::f_and: result = issue.op_a & issue.op_b;
               cpu_pkg::f_or:  result = issue.op_a | issue.op_b;
               cpu_pkg::f_xor: result = issue.op_a ^ issue.op_b;
               default:        illegal = 1'b1;
            endcase
         cpu_pkg::op_addi: result = issue.op_a + imm_sext;
         cpu_pkg::op_ori:  result = issue.op_a | imm_sext;
         default:          illegal = 1'b1;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (reset)
         commit.valid <= 1'b0;
      else
         commit.valid <= issue.valid;
   end

   // Commit record payload
   always_ff @(posedge clk)
   begin
      if (issue.valid)
      begin
         commit.pc    <= issue.pc;
         commit.insn  <= issue.insn;
         commit.waddr <= issue.insn.r.rd;
         commit.wdata <= result;
         commit.excp  <= illegal;
         commit.we    <= !illegal && issue.insn.r.rd != '0;
      end
   end

endmodule

`default_nettype wire

/* verilog/commit_trace.sv */
`timescale 1ns/1ps
`default_nettype none

module commit_trace
(
   input  logic                       clk,
   input  logic                       reset,
   commit_if.sink                     commit,
   output logic                       trace_valid,
   output logic                       trace_we,
   output logic                       trace_excp,
   output logic [cpu_pkg::xlen-1:0]   trace_pc,
   output logic [cpu_pkg::xlen-1:0]   trace_insn,
   output logic [cpu_pkg::xlen-1:0]   trace_wdata,
   output logic [31:0]                trace_excp_vect,
   output logic [cpu_pkg::reg_aw-1:0] trace_waddr
);
   logic [cpu_pkg::xlen-1:0] last_pc;
   logic                     seen;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         trace_valid <= 1'b0;
         seen        <= 1'b0;
      end
      else
      begin
         trace_valid <= commit.valid;
         if (trace_valid)
         begin
            seen    <= 1'b1;
            last_pc <= trace_pc;
         end
      end
   end

   // Record held until the next commit
   always_ff @(posedge clk)
   begin
      if (commit.valid)
      begin
         trace_pc        <= commit.pc;
         trace_insn      <= commit.insn;
         trace_we        <= commit.we;
         trace_waddr     <= commit.waddr;
         trace_wdata     <= commit.wdata;
         trace_excp      <= commit.excp;
         trace_excp_vect <= commit.excp ? cpu_pkg::excp_vect_illegal : '0;
      end
   end

   a_pc_order: assert property (@(posedge clk) disable iff (reset)
      trace_valid && seen |-> trace_pc == last_pc + cpu_pkg::xlen'(4));

   a_we_excp: assert property (@(posedge clk) disable iff (reset)
      trace_valid |-> !(trace_we && trace_excp));

endmodule

`default_nettype wire

/* verilog/cpu_top.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_top
#(
   parameter logic [cpu_pkg::xlen-1:0] RESET_PC = '0
)
(
   input  logic                       clk,
   input  logic                       reset,
   output logic                       wb_cyc,
   output logic                       wb_stb,
   output logic                       wb_we,
   output logic [cpu_pkg::xlen-1:0]   wb_adr,
   input  logic [cpu_pkg::xlen-1:0]   wb_dat_i,
   input  logic                       wb_ack,
   output logic                       trace_valid,
   output logic                       trace_we,
   output logic                       trace_excp,
   output logic [cpu_pkg::xlen-1:0]   trace_pc,
   output logic [cpu_pkg::xlen-1:0]   trace_insn,
   output logic [cpu_pkg::xlen-1:0]   trace_wdata,
   output logic [31:0]                trace_excp_vect,
   output logic [cpu_pkg::reg_aw-1:0] trace_waddr
);
   fetch_if  fetch_bus ();
   issue_if  issue_bus ();
   commit_if commit_bus ();

   // Instruction bus only reads
   assign wb_we = 1'b0;

   fetch_wb #(.RESET_PC(RESET_PC)) u_fetch (
      .clk      (clk),
      .reset    (reset),
      .wb_cyc   (wb_cyc),
      .wb_stb   (wb_stb),
      .wb_adr   (wb_adr),
      .wb_dat_i (wb_dat_i),
      .wb_ack   (wb_ack),
      .fetch    (fetch_bus)
   );

   decode_stage u_decode (
      .clk    (clk),
      .reset  (reset),
      .fetch  (fetch_bus),
      .issue  (issue_bus),
      .commit (commit_bus)
   );

   execute_stage u_execute (
      .clk    (clk),
      .reset  (reset),
      .issue  (issue_bus),
      .commit (commit_bus)
   );

   commit_trace u_trace (
      .clk             (clk),
      .reset           (reset),
      .commit          (commit_bus),
      .trace_valid     (trace_valid),
      .trace_we        (trace_we),
      .trace_excp      (trace_excp),
      .trace_pc        (trace_pc),
      .trace_insn      (trace_insn),
      .trace_wdata     (trace_wdata),
      .trace_excp_vect (trace_excp_vect),
      .trace_waddr     (trace_waddr)
   );

endmodule

`default_nettype wire

/* verification/tb_wb_memory.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_wb_memory
(
   input  logic        clk,
   input  logic        reset,
   input  logic        wb_cyc,
   input  logic        wb_stb,
   input  logic [31:0] wb_adr,
   input  logic [1:0]  ack_delay,
   output logic [31:0] wb_dat,
   output logic        wb_ack
);
   logic [31:0] mem [0:255];
   logic [31:0] dat_q = '0;
   logic        ack_q = 1'b0;
   logic        busy = 1'b0;
   logic [1:0]  wait_left = '0;

   assign wb_dat = dat_q;
   assign wb_ack = ack_q;

   // Ack delay is taken once per request, then counted down
   always @(negedge clk)
   begin
      if (reset)
      begin
         ack_q <= 1'b0;
         busy  <= 1'b0;
      end
      else if (ack_q)
      begin
         ack_q <= 1'b0;
         busy  <= 1'b0;
      end
      else if (wb_cyc && wb_stb)
      begin
         if ((!busy && ack_delay == 2'd0) || (busy && wait_left == 2'd0))
         begin
            ack_q <= 1'b1;
            dat_q <= mem[wb_adr[9:2]];
         end
         else if (!busy)
            wait_left <= ack_delay - 2'd1;
         else
            wait_left <= wait_left - 2'd1;
         busy <= 1'b1;
      end
   end

endmodule

`default_nettype wire

/* verification/cpu_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_tb;
   localparam int num_words = 256;
   localparam int timeout_cycles = num_words * 12 + 200;

   logic        clk = 1'b0;
   logic        reset = 1'b1;
   logic [1:0]  ack_delay = 2'd0;
   logic        wb_cyc;
   logic        wb_stb;
   logic        wb_we;
   logic        wb_ack;
   logic [31:0] wb_adr;
   logic [31:0] wb_dat_i;
   logic        trace_valid;
   logic        trace_we;
   logic        trace_excp;
   logic [31:0] trace_pc;
   logic [31:0] trace_insn;
   logic [31:0] trace_wdata;
   logic [31:0] trace_excp_vect;
   logic [4:0]  trace_waddr;
   logic [31:0] prog [0:num_words-1];
   logic [31:0] gold [0:31];
   logic [31:0] expect_pc = '0;
   logic [31:0] held_adr = '0;
   logic        stb_waiting = 1'b0;
   int          records = 0;
   int          cycles = 0;

   cpu_top #(.RESET_PC(32'h0)) dut (
      .clk             (clk),
      .reset           (reset),
      .wb_cyc          (wb_cyc),
      .wb_stb          (wb_stb),
      .wb_we           (wb_we),
      .wb_adr          (wb_adr),
      .wb_dat_i        (wb_dat_i),
      .wb_ack          (wb_ack),
      .trace_valid     (trace_valid),
      .trace_we        (trace_we),
      .trace_excp      (trace_excp),
      .trace_pc        (trace_pc),
      .trace_insn      (trace_insn),
      .trace_wdata     (trace_wdata),
      .trace_excp_vect (trace_excp_vect),
      .trace_waddr     (trace_waddr)
   );

   tb_wb_memory imem (
      .clk       (clk),
      .reset     (reset),
      .wb_cyc    (wb_cyc),
      .wb_stb    (wb_stb),
      .wb_adr    (wb_adr),
      .ack_delay (ack_delay),
      .wb_dat    (wb_dat_i),
      .wb_ack    (wb_ack)
   );

   always #4 clk = ~clk;

   always @(posedge clk)
      cycles <= cycles + 1;

   task automatic stop_run(input string line);
      $display("%s", line);
      $display("Something failed");
      $fatal(1, "stopping at the first error");
   endtask

   task automatic expect_value(input string what, input logic [31:0] got,
                               input logic [31:0] want);
      assert (got == want)
      else stop_run($sformatf("** Error at %0t: %s is %h, expected %h", $time, what, got, want));
   endtask

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   // Registers stay in 0..7, so half the sources hit the previous rd
   function automatic logic [31:0] random_insn(input logic [31:0] r, input logic [4:0] last_rd);
      logic [4:0]  rd;
      logic [4:0]  rs1;
      logic [4:0]  rs2;
      logic [5:0]  funct;
      logic [5:0]  opc;
      logic [31:0] word;
      rd  = {2'b00, r[6:4]};
      rs1 = r[7] ? last_rd : {2'b00, r[10:8]};
      rs2 = r[11] ? last_rd : {2'b00, r[14:12]};
      opc = r[31:26];
      case (r[18:16])
         3'd0, 3'd5: funct = cpu_pkg::f_add;
         3'd1, 3'd6: funct = cpu_pkg::f_sub;
         3'd2, 3'd7: funct = cpu_pkg::f_and;
         3'd3:       funct = cpu_pkg::f_or;
         default:    funct = cpu_pkg::f_xor;
      endcase
      if (r[3:0] == 4'h0 && r[19])
      begin
         if (opc == cpu_pkg::op_alu || opc == cpu_pkg::op_addi || opc == cpu_pkg::op_ori)
            opc = 6'h3f;
         word = {opc, r[25:0]};
      end
      else if (r[3:0] == 4'h0)
         word = {cpu_pkg::op_alu, rd, rs1, rs2, 5'd0, 1'b1, r[24:20]};
      else if (r[3])
         word = {cpu_pkg::op_alu, rd, rs1, rs2, 5'd0, funct};
      else if (r[15])
         word = {cpu_pkg::op_addi, rd, rs1, r[31:16]};
      else
         word = {cpu_pkg::op_ori, rd, rs1, r[31:16]};
      return word;
   endfunction

   task automatic check_record();
      logic [4:0]  rd;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] imm;
      logic [31:0] res;
      logic        legal;
      rd    = trace_insn[25:21];
      a     = gold[trace_insn[20:16]];
      b     = gold[trace_insn[15:11]];
      imm   = {{16{trace_insn[15]}}, trace_insn[15:0]};
      res   = '0;
      legal = 1'b1;
      if (trace_insn[31:26] == cpu_pkg::op_alu)
      begin
         case (trace_insn[5:0])
            cpu_pkg::f_add: res = a + b;
            cpu_pkg::f_sub: res = a - b;
            cpu_pkg::f_and: res = a & b;
            cpu_pkg::f_or:  res = a | b;
            cpu_pkg::f_xor: res = a ^ b;
            default:        legal = 1'b0;
         endcase
      end
      else if (trace_insn[31:26] == cpu_pkg::op_addi)
         res = a + imm;
      else if (trace_insn[31:26] == cpu_pkg::op_ori)
         res = a | imm;
      else
         legal = 1'b0;
      expect_value("trace_pc", trace_pc, expect_pc);
      expect_value("trace_insn", trace_insn, prog[trace_pc[9:2]]);
      if (legal)
      begin
         expect_value("trace_excp", 32'(trace_excp), 32'd0);
         expect_value("trace_waddr", 32'(trace_waddr), 32'(rd));
         expect_value("trace_we", 32'(trace_we), 32'(rd != 5'd0));
         expect_value("trace_wdata", trace_wdata, res);
         if (rd != 5'd0)
            gold[rd] = res;
      end
      else
      begin
         expect_value("trace_excp", 32'(trace_excp), 32'd1);
         expect_value("trace_excp_vect", trace_excp_vect, cpu_pkg::excp_vect_illegal);
         expect_value("trace_we", 32'(trace_we), 32'd0);
      end
      expect_pc = expect_pc + 32'd4;
      records = records + 1;
   endtask

   always @(posedge clk)
   begin
      if (reset)
      begin
         expect_pc = '0;
         records = 0;
         for (int k = 0; k < 32; k++)
            gold[k] = '0;
      end
      else if (trace_valid)
         check_record();
   end

   // Classic Wishbone rules on every fetch
   always @(posedge clk)
   begin
      if (reset)
         stb_waiting <= 1'b0;
      else
      begin
         assert (!wb_stb || wb_cyc) else stop_run("wb_stb is high without wb_cyc");
         assert (!wb_cyc || !wb_we) else stop_run("wb_we is high on an instruction fetch");
         if (stb_waiting)
         begin
            assert (wb_stb && wb_adr == held_adr)
            else stop_run($sformatf("** Error at %0t: wb_adr %h, expected %h held until ack",
                                    $time, wb_adr, held_adr));
         end
         stb_waiting <= wb_stb && !wb_ack;
         held_adr    <= wb_adr;
      end
   end

   initial
   begin
      logic [31:0] rng;
      logic [4:0]  last_rd;
      rng = 32'h9fef_58f7;
      last_rd = 5'd0;
      // First words load r1..r7 from r0 so no register is read unwritten
      for (int i = 0; i < num_words; i++)
      begin
         rng = xorshift32(rng);
         if (i < 7)
            prog[i] = {cpu_pkg::op_ori, 5'(i + 1), 5'd0, rng[15:0]};
         else
            prog[i] = random_insn(rng, last_rd);
         last_rd = {2'b00, prog[i][23:21]};
         imem.mem[i] = prog[i];
      end
      repeat (10)
      begin
         @(negedge clk);
         assert (!trace_valid && !wb_cyc) else stop_run("trace_valid or wb_cyc high in reset");
      end
      reset = 1'b0;
      #1;
      assert (!trace_valid && !wb_cyc) else stop_run("trace_valid or wb_cyc high after reset");
      while (records < num_words && cycles < timeout_cycles)
      begin
         @(negedge clk);
         rng = xorshift32(rng);
         ack_delay <= rng[1:0];
      end
      if (records >= num_words)
      begin
         $display("Everything OK");
         $finish;
      end
      else
         stop_run($sformatf("timeout after %0d cycles with %0d of %0d trace records",
                            cycles, records, num_words));
   end

endmodule

`default_nettype wire

/* filelist.f */
verilog/cpu_pkg.sv
verilog/pipe_if.sv
verilog/fetch_wb.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/commit_trace.sv
verilog/cpu_top.sv
verification/tb_wb_memory.sv
verification/cpu_tb.sv

/* run.sh */
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module cpu_tb -f filelist.f -o cpu_sim

# The log decides the result, so a fatal stop must not end the script here
./obj_dir/cpu_sim > sim.log 2>&1 || true
cat sim.log

if grep -qx "Everything OK" sim.log
then
   echo "Simulation passed"
else
   echo "Simulation failed, see sim.log"
   exit 1
fi
